/* design/frogger_cfg.svh */
`ifndef FROGGER_CFG_SVH
`define FROGGER_CFG_SVH

// Pixel coordinate width, wide enough for 0..511
`define COORD_W 9

// Screen geometry
`define SCREEN_W 320
`define SCREEN_H 240

// Frog sprite size
`define FROG_W 32
`define FROG_H 24

// River log size
`define LOG_W 96
`define LOG_H 30

// Top rows of the three log lanes
`define LOG_1_Y 75
`define LOG_2_Y 115
`define LOG_3_Y 155

// Starting left columns of the logs
`define LOG_1_X0 0
`define LOG_2_X0 319
`define LOG_3_X0 0

// Solid fill colours, 3-bit RGB
`define START_COLOR     3'd1
`define GAME_OVER_COLOR 3'd4
`define BG_COLOR        3'd2
`define LOG_COLOR       3'd6
`define FROG_COLOR      3'd3

`endif

/* design/frogger_pkg.sv */
`include "frogger_cfg.svh"

package frogger_pkg;

    // Screen coordinate, also used for rectangle sizes and offsets
    typedef logic [`COORD_W-1:0] coord_t;

    // One pixel colour, one bit per channel
    typedef logic [2:0] color_t;

    // Drawing currently in progress
    typedef enum logic [2:0] {
        DRAW_NONE      = 3'd0,
        DRAW_START     = 3'd1,
        DRAW_GAME_OVER = 3'd2,
        DRAW_BG        = 3'd3,
        DRAW_LOG_1     = 3'd4,
        DRAW_LOG_2     = 3'd5,
        DRAW_LOG_3     = 3'd6,
        DRAW_FROG      = 3'd7
    } draw_op_e;

    // Control FSM states
    // Wait states hold for go, draw states hold for done
    typedef enum logic [3:0] {
        S_WAIT_START     = 4'd0,
        S_DRAW_START     = 4'd1,
        S_WAIT_GAME_OVER = 4'd2,
        S_DRAW_GAME_OVER = 4'd3,
        S_WAIT_BG        = 4'd4,
        S_DRAW_BG        = 4'd5,
        S_DRAW_LOG_1     = 4'd6,
        S_DRAW_LOG_2     = 4'd7,
        S_DRAW_LOG_3     = 4'd8,
        S_DRAW_FROG      = 4'd9
    } ctrl_state_e;

endpackage

/* design/pixel_if.sv */
`timescale 1ns/10ps

interface pixel_if
    import frogger_pkg::*;
();

    // Pixel write strobe, one pixel per cycle while high
    logic   plot;

    // Pixel address on the 320x240 screen
    coord_t x;
    coord_t y;

    // Pixel colour
    color_t color;

    // Producer side, the sprite datapath
    modport datapath (output plot, output x, output y, output color);

    // Consumer side, a frame buffer or pixel port
    modport sink (input plot, input x, input y, input color);

endinterface

/* design/go_pulse.sv */
`timescale 1ns/10ps

module go_pulse (
    input  logic clk,
    input  logic reset,
    input  logic key_go,
    output logic go
);

    // Key handler states
    typedef enum logic [1:0] {
        GS_WAIT_KEY     = 2'd0,
        GS_GO_1         = 2'd1,
        GS_GO_2         = 2'd2,
        GS_WAIT_RELEASE = 2'd3
    } go_state_e;

    go_state_e state;
    go_state_e next_state;

    always_comb begin
        next_state = state;
        case (state)
            // Press seen, start the pulse next cycle
            GS_WAIT_KEY:     next_state = key_go ? GS_GO_1 : GS_WAIT_KEY;
            GS_GO_1:         next_state = GS_GO_2;
            GS_GO_2:         next_state = GS_WAIT_RELEASE;
            // Key must drop before another pulse
            GS_WAIT_RELEASE: next_state = key_go ? GS_WAIT_RELEASE : GS_WAIT_KEY;
            default:         next_state = GS_WAIT_KEY;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= GS_WAIT_KEY;
        end else begin
            state <= next_state;
        end
    end

    // Go is high in the two pulse states only
    assign go = (state == GS_GO_1) || (state == GS_GO_2);

    // Pulse never stretches past two cycles, even with the key held
    assert property (@(posedge clk) disable iff (reset)
        (go && $past(go)) |-> !$past(go, 2));

endmodule

/* design/draw_control.sv */
`timescale 1ns/10ps

module draw_control
    import frogger_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     go,
    input  logic     done,
    output draw_op_e op
);

    ctrl_state_e state;
    ctrl_state_e next_state;

    // Next-state logic
    always_comb begin
        next_state = state;
        case (state)
            // Title screen, drawn on the first press
            S_WAIT_START: begin
                if (go) begin
                    next_state = S_DRAW_START;
                end
            end
            S_DRAW_START: begin
                if (done) begin
                    next_state = S_WAIT_GAME_OVER;
                end
            end

            // Game-over screen on the second press
            S_WAIT_GAME_OVER: begin
                if (go) begin
                    next_state = S_DRAW_GAME_OVER;
                end
            end
            S_DRAW_GAME_OVER: begin
                if (done) begin
                    next_state = S_WAIT_BG;
                end
            end

            // Third press enters the game loop
            S_WAIT_BG: begin
                if (go) begin
                    next_state = S_DRAW_BG;
                end
            end

            // Game loop, background then logs then frog, no waits
            S_DRAW_BG: begin
                if (done) begin
                    next_state = S_DRAW_LOG_1;
                end
            end
            S_DRAW_LOG_1: begin
                if (done) begin
                    next_state = S_DRAW_LOG_2;
                end
            end
            S_DRAW_LOG_2: begin
                if (done) begin
                    next_state = S_DRAW_LOG_3;
                end
            end
            S_DRAW_LOG_3: begin
                if (done) begin
                    next_state = S_DRAW_FROG;
                end
            end
            S_DRAW_FROG: begin
                // Back to the background, loop runs forever
                if (done) begin
                    next_state = S_DRAW_BG;
                end
            end

            default: begin
                next_state = S_WAIT_START;
            end
        endcase
    end

    // State register
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= S_WAIT_START;
        end else begin
            state <= next_state;
        end
    end

    // Op decode, held level for the whole drawing
    always_comb begin
        case (state)
            S_DRAW_START:     op = DRAW_START;
            S_DRAW_GAME_OVER: op = DRAW_GAME_OVER;
            S_DRAW_BG:        op = DRAW_BG;
            S_DRAW_LOG_1:     op = DRAW_LOG_1;
            S_DRAW_LOG_2:     op = DRAW_LOG_2;
            S_DRAW_LOG_3:     op = DRAW_LOG_3;
            S_DRAW_FROG:      op = DRAW_FROG;
            // Wait states draw nothing
            default:          op = DRAW_NONE;
        endcase
    end

    // Plotter only finishes a rectangle that this FSM asked for
    assert property (@(posedge clk) disable iff (reset)
        done |-> (op != DRAW_NONE));

endmodule

/* design/raster_plotter.sv */
`timescale 1ns/10ps

module raster_plotter
    import frogger_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  logic   enable,
    input  coord_t width,
    input  coord_t height,
    output coord_t offset_x,
    output coord_t offset_y,
    output logic   done
);

    logic last_x;
    logic last_y;

    // End of row and end of column
    assign last_x = (offset_x == width - coord_t'(1));
    assign last_y = (offset_y == height - coord_t'(1));

    // Two-dimensional scan, x steps first then y
    always_ff @(posedge clk) begin
        if (reset) begin
            offset_x <= '0;
            offset_y <= '0;
        end else if (enable) begin
            if (last_x) begin
                offset_x <= '0;
                // Wraps to the origin after the last pixel
                offset_y <= last_y ? '0 : offset_y + coord_t'(1);
            end else begin
                offset_x <= offset_x + coord_t'(1);
            end
        end else begin
            // Idle between drawings, parked at the origin
            offset_x <= '0;
            offset_y <= '0;
        end
    end

    // Last pixel of the rectangle
    assign done = enable && last_x && last_y;

    // Offsets stay inside the rectangle the datapath requested
    assert property (@(posedge clk) disable iff (reset)
        enable |-> (offset_x < width) && (offset_y < height));

endmodule

/* design/sprite_datapath.sv */
`timescale 1ns/10ps
`include "frogger_cfg.svh"

module sprite_datapath
    import frogger_pkg::*;
(
    input  logic           clk,
    input  logic           reset,
    input  draw_op_e       op,
    input  logic           done,
    input  coord_t         offset_x,
    input  coord_t         offset_y,
    input  logic           up,
    input  logic           down,
    input  logic           left,
    input  logic           right,
    output logic           enable,
    output coord_t         width,
    output coord_t         height,
    pixel_if.datapath      pix
);

    // Frog top-left limits keep the whole sprite on screen
    localparam coord_t FROG_X_MAX = coord_t'(`SCREEN_W - `FROG_W);
    localparam coord_t FROG_Y_MAX = coord_t'(`SCREEN_H - `FROG_H);
    localparam coord_t X_LAST     = coord_t'(`SCREEN_W - 1);

    // Object positions, top-left corners
    coord_t log_1_x;
    coord_t log_2_x;
    coord_t log_3_x;
    coord_t frog_x;
    coord_t frog_y;

    // Current rectangle origin and colour
    coord_t origin_x;
    coord_t origin_y;
    color_t fill_color;
    logic   is_log;

    coord_t pixel_x;
    coord_t pixel_y;
    logic   clipped;

    coord_t frog_next_x;
    coord_t frog_next_y;

    // Rectangle size, origin and colour per drawing
    always_comb begin
        width      = coord_t'(`SCREEN_W);
        height     = coord_t'(`SCREEN_H);
        origin_x   = '0;
        origin_y   = '0;
        fill_color = '0;
        is_log     = 1'b0;
        case (op)
            DRAW_START:     fill_color = `START_COLOR;
            DRAW_GAME_OVER: fill_color = `GAME_OVER_COLOR;
            DRAW_BG:        fill_color = `BG_COLOR;
            DRAW_LOG_1, DRAW_LOG_2, DRAW_LOG_3: begin
                width      = coord_t'(`LOG_W);
                height     = coord_t'(`LOG_H);
                fill_color = `LOG_COLOR;
                is_log     = 1'b1;
                // Lane row and column of the selected log
                if (op == DRAW_LOG_1) begin
                    origin_x = log_1_x;
                    origin_y = coord_t'(`LOG_1_Y);
                end else if (op == DRAW_LOG_2) begin
                    origin_x = log_2_x;
                    origin_y = coord_t'(`LOG_2_Y);
                end else begin
                    origin_x = log_3_x;
                    origin_y = coord_t'(`LOG_3_Y);
                end
            end
            DRAW_FROG: begin
                width      = coord_t'(`FROG_W);
                height     = coord_t'(`FROG_H);
                origin_x   = frog_x;
                origin_y   = frog_y;
                fill_color = `FROG_COLOR;
            end
            default: begin
                width  = '0;
                height = '0;
            end
        endcase
    end

    assign enable = (op != DRAW_NONE);

    // Screen address, max 319 + 95 still fits in 9 bits
    assign pixel_x = origin_x + offset_x;
    assign pixel_y = origin_y + offset_y;

    // Log pixels past the right edge are dropped
    assign clipped = is_log && (pixel_x >= coord_t'(`SCREEN_W));

    // Frog step, right minus left and down minus up, clamped
    always_comb begin
        frog_next_x = frog_x;
        frog_next_y = frog_y;
        if (right && !left && (frog_x < FROG_X_MAX)) begin
            frog_next_x = frog_x + coord_t'(1);
        end else if (left && !right && (frog_x != '0)) begin
            frog_next_x = frog_x - coord_t'(1);
        end
        if (down && !up && (frog_y < FROG_Y_MAX)) begin
            frog_next_y = frog_y + coord_t'(1);
        end else if (up && !down && (frog_y != '0)) begin
            frog_next_y = frog_y - coord_t'(1);
        end
    end

    // Positions move once per loop, at the end of each object's drawing
    always_ff @(posedge clk) begin
        if (reset) begin
            log_1_x <= coord_t'(`LOG_1_X0);
            log_2_x <= coord_t'(`LOG_2_X0);
            log_3_x <= coord_t'(`LOG_3_X0);
            frog_x  <= '0;
            frog_y  <= '0;
        end else if (done) begin
            case (op)
                // Lanes 1 and 3 drift right, lane 2 drifts left
                DRAW_LOG_1: log_1_x <= (log_1_x == X_LAST) ? '0 : log_1_x + coord_t'(1);
                DRAW_LOG_2: log_2_x <= (log_2_x == '0) ? X_LAST : log_2_x - coord_t'(1);
                DRAW_LOG_3: log_3_x <= (log_3_x == X_LAST) ? '0 : log_3_x + coord_t'(1);
                DRAW_FROG: begin
                    frog_x <= frog_next_x;
                    frog_y <= frog_next_y;
                end
                default: begin
                end
            endcase
        end
    end

    // Pixel strobe, one cycle behind the offset
    always_ff @(posedge clk) begin
        if (reset) begin
            pix.plot <= 1'b0;
        end else begin
            pix.plot <= enable && !clipped;
        end
    end

    // Pixel address and colour travel with the strobe
    always_ff @(posedge clk) begin
        pix.x     <= pixel_x;
        pix.y     <= pixel_y;
        pix.color <= fill_color;
    end

    // Frog sprite never leaves the screen
    assert property (@(posedge clk) disable iff (reset)
        (frog_x <= FROG_X_MAX) && (frog_y <= FROG_Y_MAX));

endmodule

/* design/frogger_top.sv */
`timescale 1ns/10ps

module frogger_top
    import frogger_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  logic   key_go,
    input  logic   up,
    input  logic   down,
    input  logic   left,
    input  logic   right,
    output logic   plot,
    output coord_t x,
    output coord_t y,
    output color_t color
);

    logic     go;
    logic     done;
    logic     enable;
    draw_op_e op;
    coord_t   width;
    coord_t   height;
    coord_t   offset_x;
    coord_t   offset_y;

    // Pixel bus from the datapath
    pixel_if pix_bus ();

    // Go key to two-cycle pulse
    go_pulse go_pulse_inst (
        .clk    (clk),
        .reset  (reset),
        .key_go (key_go),
        .go     (go)
    );

    // Screen and loop sequencing
    draw_control draw_control_inst (
        .clk   (clk),
        .reset (reset),
        .go    (go),
        .done  (done),
        .op    (op)
    );

    // Rectangle scan
    raster_plotter raster_plotter_inst (
        .clk      (clk),
        .reset    (reset),
        .enable   (enable),
        .width    (width),
        .height   (height),
        .offset_x (offset_x),
        .offset_y (offset_y),
        .done     (done)
    );

    // Positions and pixel generation
    sprite_datapath sprite_datapath_inst (
        .clk      (clk),
        .reset    (reset),
        .op       (op),
        .done     (done),
        .offset_x (offset_x),
        .offset_y (offset_y),
        .up       (up),
        .down     (down),
        .left     (left),
        .right    (right),
        .enable   (enable),
        .width    (width),
        .height   (height),
        .pix      (pix_bus.datapath)
    );

    // Bus out to plain pixel ports
    assign plot  = pix_bus.plot;
    assign x     = pix_bus.x;
    assign y     = pix_bus.y;
    assign color = pix_bus.color;

endmodule

/* sim/clock_gen.sv */
`timescale 1ns/10ps

module clock_gen (
    output logic clk,
    output logic reset
);

    // 40 ns period, 25 MHz
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Reset covers three rising edges, released on a falling edge
    initial begin
        reset = 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

/* sim/frogger_tb.sv */
`timescale 1ns/10ps
`include "frogger_cfg.svh"

module frogger_tb
    import frogger_pkg::*;
();

    // Run length in loops and the watchdog limit derived from it
    localparam int LOOPS       = 8;
    localparam int FILL_PIX    = `SCREEN_W * `SCREEN_H;
    localparam int LOOP_PIX    = FILL_PIX + 3 * `LOG_W * `LOG_H + `FROG_W * `FROG_H;
    localparam int TOTAL_CYC   = 3 * FILL_PIX + LOOPS * LOOP_PIX;
    localparam int TIMEOUT_NS  = TOTAL_CYC * 40 * 12 / 10;
    localparam int FROG_X_LIM  = `SCREEN_W - `FROG_W;
    localparam int FROG_Y_LIM  = `SCREEN_H - `FROG_H;

    logic   clk;
    logic   reset;
    logic   key_go;
    logic   up;
    logic   down;
    logic   left;
    logic   right;
    logic   plot;
    coord_t x;
    coord_t y;
    color_t color;

    int mismatch_count = 0;
    int fail_count     = 0;
    int press_count    = 0;
    int draws_done     = 0;
    int bg_starts      = 0;
    int loops_done     = 0;
    logic [31:0] rand_state;

    // Model of the drawing sequence
    // 0 start, 1 game over, 2 background, 3..5 logs, 6 frog
    int cycle_count = 0;
    int draw_idx    = 0;
    int pix_count   = 0;
    int raster_idx  = 0;
    int start_cycle = 0;
    int exp_w, exp_h, exp_ox, exp_oy, exp_total;
    color_t exp_color;
    int log_x [1:3] = '{`LOG_1_X0, `LOG_2_X0, `LOG_3_X0};
    int frog_x_m    = 0;
    int frog_y_m    = 0;

    clock_gen clock_gen_inst (
        .clk   (clk),
        .reset (reset)
    );

    frogger_top frogger_top_inst (
        .clk    (clk),
        .reset  (reset),
        .key_go (key_go),
        .up     (up),
        .down   (down),
        .left   (left),
        .right  (right),
        .plot   (plot),
        .x      (x),
        .y      (y),
        .color  (color)
    );

    // Linear congruential generator, seeded once
    function automatic int rand_below(input int n);
        rand_state = rand_state * 32'd1103515245 + 32'd12345;
        return int'(rand_state[30:16]) % n;
    endfunction

    function automatic int clamp_range(input int v, input int hi);
        if (v < 0) begin
            return 0;
        end
        return (v > hi) ? hi : v;
    endfunction

    // Rectangle, origin and colour of a drawing from the screen rules
    task automatic load_drawing(input int idx);
        exp_ox = 0;
        exp_oy = 0;
        exp_w  = `SCREEN_W;
        exp_h  = `SCREEN_H;
        case (idx)
            0:       exp_color = `START_COLOR;
            1:       exp_color = `GAME_OVER_COLOR;
            2:       exp_color = `BG_COLOR;
            6: begin
                exp_w     = `FROG_W;
                exp_h     = `FROG_H;
                exp_ox    = frog_x_m;
                exp_oy    = frog_y_m;
                exp_color = `FROG_COLOR;
            end
            default: begin
                exp_w     = `LOG_W;
                exp_h     = `LOG_H;
                exp_ox    = log_x[idx - 2];
                exp_oy    = (idx == 3) ? `LOG_1_Y : (idx == 4) ? `LOG_2_Y : `LOG_3_Y;
                exp_color = `LOG_COLOR;
            end
        endcase
        // Columns past the right edge are never plotted
        if (exp_ox + exp_w > `SCREEN_W) begin
            exp_total = exp_h * (`SCREEN_W - exp_ox);
        end else begin
            exp_total = exp_h * exp_w;
        end
    endtask

    // Object moves at the end of its drawing, then on to the next one
    task automatic end_drawing();
        draws_done++;
        case (draw_idx)
            3: log_x[1] = (log_x[1] == `SCREEN_W - 1) ? 0 : log_x[1] + 1;
            4: log_x[2] = (log_x[2] == 0) ? `SCREEN_W - 1 : log_x[2] - 1;
            5: log_x[3] = (log_x[3] == `SCREEN_W - 1) ? 0 : log_x[3] + 1;
            6: begin
                frog_x_m = clamp_range(frog_x_m + int'(right) - int'(left), FROG_X_LIM);
                frog_y_m = clamp_range(frog_y_m + int'(down) - int'(up), FROG_Y_LIM);
                loops_done++;
            end
            default: begin
            end
        endcase
        draw_idx  = (draw_idx == 6) ? 2 : draw_idx + 1;
        pix_count = 0;
    endtask

    task automatic check_pixel();
        int ex;
        int ey;
        if (pix_count == 0) begin
            // Screens before the loop each need their own press
            if (draw_idx <= 2 && press_count <= draw_idx) begin
                fail_count++;
                $display("ERROR at %0t: drawing %0d started with no go press", $time, draw_idx);
            end
            load_drawing(draw_idx);
            start_cycle = cycle_count;
            raster_idx  = 0;
            if (draw_idx == 2) begin
                bg_starts++;
            end
        end else begin
            raster_idx++;
            while (exp_ox + raster_idx % exp_w >= `SCREEN_W) begin
                raster_idx++;
            end
        end
        ex = exp_ox + raster_idx % exp_w;
        ey = exp_oy + raster_idx / exp_w;
        // One raster position per cycle, skipped pixels leave gaps
        assert (cycle_count - start_cycle == raster_idx) else begin
            mismatch_count++;
            $display("MISMATCH at %0t: drawing %0d pixel %0d came %0d cycles after its start",
                     $time, draw_idx, raster_idx, cycle_count - start_cycle);
        end
        assert (int'(x) == ex && int'(y) == ey) else begin
            mismatch_count++;
            $display("MISMATCH at %0t: drawing %0d pixel at (%0d, %0d), expected (%0d, %0d)",
                     $time, draw_idx, x, y, ex, ey);
        end
        assert (color == exp_color) else begin
            mismatch_count++;
            $display("MISMATCH at %0t: drawing %0d colour %0d, expected %0d",
                     $time, draw_idx, color, exp_color);
        end
        pix_count++;
        if (pix_count == exp_total) begin
            end_drawing();
        end
    endtask

    // Registered outputs are stable at the falling edge
    always @(negedge clk) begin
        if (!reset) begin
            cycle_count++;
            if (plot) begin
                check_pixel();
            end
        end
    end

    // No pixel ever lands off screen, clipped log pixels included
    assert property (@(posedge clk) disable iff (reset)
        plot |-> (int'(x) < `SCREEN_W) && (int'(y) < `SCREEN_H))
    else begin
        mismatch_count++;
        $display("MISMATCH at %0t: pixel (%0d, %0d) is off screen", $time, x, y);
    end

    task automatic press_key(input int hold_cycles);
        @(negedge clk);
        key_go = 1'b1;
        press_count++;
        repeat (hold_cycles) @(negedge clk);
        key_go = 1'b0;
    endtask

    initial begin
        key_go     = 1'b0;
        up         = 1'b0;
        down       = 1'b0;
        left       = 1'b0;
        right      = 1'b0;
        rand_state = 32'd62009;
        wait (!reset);
        // Idle after reset, nothing may be plotted
        repeat (20 + rand_below(80)) @(negedge clk);

        // First key held through the whole start fill
        @(negedge clk);
        key_go = 1'b1;
        press_count++;
        wait (draws_done >= 1);
        repeat (10 + rand_below(190)) @(negedge clk);
        key_go = 1'b0;

        repeat (20 + rand_below(80)) @(negedge clk);
        press_key(2 + rand_below(40));
        wait (draws_done >= 2);
        repeat (20 + rand_below(80)) @(negedge clk);
        press_key(2 + rand_below(40));

        // New directions early in each loop's background
        for (int k = 0; k < LOOPS; k++) begin
            wait (bg_starts > k);
            @(negedge clk);
            if (k == 0) begin
                // Frog sits at the origin, push it against both edges
                {up, down, left, right} = 4'b1010;
            end else begin
                {up, down, left, right} = 4'(rand_below(16));
            end
        end

        wait (loops_done == LOOPS);
        repeat (4) @(negedge clk);
        $display("Errors: %0d mismatches, %0d other failures", mismatch_count, fail_count);
        if (mismatch_count == 0 && fail_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    // Watchdog sized from the fills and loops plus margin
    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the drawing loops did not finish within %0d ns", TIMEOUT_NS);
        $display("Some tests failed");
        $finish;
    end

endmodule

/* frogger_top.f */
+incdir+design
design/frogger_pkg.sv
design/pixel_if.sv
design/go_pulse.sv
design/draw_control.sv
design/raster_plotter.sv
design/sprite_datapath.sv
design/frogger_top.sv
sim/clock_gen.sv
sim/frogger_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the frogger testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module frogger_tb \
    -f frogger_top.f -o frogger_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/frogger_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "All tests passed"; then
    exit 0
fi
exit 1
